//--- source/traffic_pkg.sv
package traffic_pkg;

    // one lamp per approach, one button per requestable phase
    localparam int LAMPS = 4;
    localparam int BUTTONS = 8;

    typedef enum logic [3:0] {
        PH_A1 = 4'd0,
        PH_B  = 4'd1,
        PH_C  = 4'd2,
        PH_D  = 4'd3,
        PH_E1 = 4'd4,
        PH_F  = 4'd5,
        PH_G  = 4'd6,
        PH_H  = 4'd7,
        PH_A2 = 4'd8,
        PH_E2 = 4'd12
    } phase_t;

    localparam phase_t RESET_PHASE = PH_B;

    // lamp masks of one phase with bit i for approach i
    typedef struct packed {
        logic [LAMPS-1:0] red;
        logic [LAMPS-1:0] green;
        logic [LAMPS-1:0] left_first;
        logic [LAMPS-1:0] yellow;
        logic [LAMPS-1:0] left_second;
        logic [LAMPS-1:0] walk_red;
        logic [LAMPS-1:0] walk_green;
    } lamp_masks_t;

    // fields in order red, green, left, yellow, left late, walk red, walk green
    localparam lamp_masks_t MASK_A1 =
        '{4'b0101, 4'b1010, 4'b0000, 4'b1010, 4'b0000, 4'b1010, 4'b0101};
    localparam lamp_masks_t MASK_A2 = MASK_A1;
    localparam lamp_masks_t MASK_B =
        '{4'b0111, 4'b1000, 4'b1000, 4'b1000, 4'b0000, 4'b1110, 4'b0001};
    localparam lamp_masks_t MASK_C =
        '{4'b1101, 4'b0010, 4'b0010, 4'b0010, 4'b0000, 4'b1011, 4'b0100};
    // protected left turns only, no crossing
    localparam lamp_masks_t MASK_D =
        '{4'b0101, 4'b0000, 4'b1010, 4'b1010, 4'b0000, 4'b1111, 4'b0000};
    localparam lamp_masks_t MASK_E1 =
        '{4'b1010, 4'b0101, 4'b0000, 4'b0101, 4'b0000, 4'b0101, 4'b1010};
    localparam lamp_masks_t MASK_E2 = MASK_E1;
    // F keeps its left arrow through yellow
    localparam lamp_masks_t MASK_F =
        '{4'b1011, 4'b0100, 4'b0100, 4'b0100, 4'b0100, 4'b0111, 4'b1000};
    localparam lamp_masks_t MASK_G =
        '{4'b1110, 4'b0001, 4'b0001, 4'b0001, 4'b0000, 4'b1101, 4'b0010};
    localparam lamp_masks_t MASK_H =
        '{4'b1010, 4'b0000, 4'b0101, 4'b0101, 4'b0000, 4'b1111, 4'b0000};
    localparam lamp_masks_t MASK_OFF = '0;

endpackage

//--- source/button_oneshot.sv
`timescale 1ns/1ns

module button_oneshot (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [traffic_pkg::BUTTONS-1:0] buttons,
    output logic [traffic_pkg::BUTTONS-1:0] press
);

    import traffic_pkg::*;

    logic [BUTTONS-1:0] buttons_q;

    // rising edge of each button, held for one cycle
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            buttons_q <= '0;
            press <= '0;
        end
        else
        begin
            buttons_q <= buttons;
            press <= buttons & ~buttons_q;
        end
    end

endmodule

//--- source/phase_timer.sv
`timescale 1ns/1ns

module phase_timer #(
    parameter int TICKS_PER_STEP = 240,
    parameter int DAY_STEPS = 40,
    parameter int NIGHT_STEPS = 80,
    parameter int MANUAL_STEPS = 120
) (
    input  logic clk,
    input  logic rst,
    input  logic night,
    input  logic manual,
    output logic phase_end,
    output logic second_half,
    output logic flash_on
);

    localparam int MAX_DN = (DAY_STEPS > NIGHT_STEPS) ? DAY_STEPS : NIGHT_STEPS;
    localparam int MAX_STEPS = (MANUAL_STEPS > MAX_DN) ? MANUAL_STEPS : MAX_DN;
    localparam int STEP_W = $clog2(MAX_STEPS + 1);
    localparam int TICK_W = (TICKS_PER_STEP > 2) ? $clog2(TICKS_PER_STEP) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_STEP - 1);
    localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(TICKS_PER_STEP / 2);

    logic [TICK_W-1:0] tick_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic [STEP_W-1:0] len_q;
    logic [STEP_W-1:0] len_sel;
    logic [STEP_W-1:0] phase_len;
    logic first_cycle;
    logic last_tick;

    // manual and night are sampled only when a phase begins
    always_comb
    begin
        if (manual)
            len_sel = STEP_W'(MANUAL_STEPS);
        else if (night)
            len_sel = STEP_W'(NIGHT_STEPS);
        else
            len_sel = STEP_W'(DAY_STEPS);
    end

    assign phase_len = first_cycle ? len_sel : len_q;
    assign last_tick = (tick_cnt == TICK_LAST);
    assign phase_end = last_tick && (step_cnt == phase_len - 1'b1);
    assign second_half = (step_cnt >= (phase_len >> 1));
    assign flash_on = (tick_cnt < TICK_HALF);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            tick_cnt <= '0;
            step_cnt <= '0;
            len_q <= '0;
            first_cycle <= 1'b1;
        end
        else
        begin
            first_cycle <= phase_end;
            if (first_cycle)
                len_q <= len_sel;
            if (last_tick)
            begin
                tick_cnt <= '0;
                if (phase_end)
                    step_cnt <= '0;
                else
                    step_cnt <= step_cnt + 1'b1;
            end
            else
            begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/phase_sequencer.sv
`timescale 1ns/1ns

module phase_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            night,
    input  logic [traffic_pkg::BUTTONS-1:0] press,
    input  logic                            phase_end,
    output traffic_pkg::phase_t             phase,
    output logic                            manual
);

    import traffic_pkg::*;

    // button bit i asks for this phase
    localparam phase_t BUTTON_MAP [0:BUTTONS-1] =
        '{PH_A1, PH_B, PH_C, PH_D, PH_E1, PH_F, PH_G, PH_H};

    phase_t req_phase;
    phase_t press_phase;
    phase_t next_phase;
    logic req_valid;

    // lowest pressed bit wins
    always_comb
    begin
        press_phase = BUTTON_MAP[0];
        for (int i = BUTTONS - 1; i >= 0; i--)
        begin
            if (press[i])
                press_phase = BUTTON_MAP[i];
        end
    end

    always_comb
    begin
        if (night)
        begin
            case (phase)
                PH_B:    next_phase = PH_A1;
                PH_A1:   next_phase = PH_C;
                PH_C:    next_phase = PH_A2;
                PH_A2:   next_phase = PH_E1;
                PH_E1:   next_phase = PH_H;
                default: next_phase = PH_B;
            endcase
        end
        else
        begin
            case (phase)
                PH_A1:   next_phase = PH_D;
                PH_D:    next_phase = PH_F;
                PH_F:    next_phase = PH_E1;
                PH_E1:   next_phase = PH_G;
                PH_G:    next_phase = PH_E2;
                default: next_phase = PH_A1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            phase <= RESET_PHASE;
            manual <= 1'b0;
            req_valid <= 1'b0;
        end
        else
        begin
            if (phase_end)
            begin
                phase <= req_valid ? req_phase : next_phase;
                manual <= req_valid;
            end
            // a new press outranks the clear on phase end
            if (|press)
                req_valid <= 1'b1;
            else if (phase_end)
                req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|press)
            req_phase <= press_phase;
    end

endmodule

//--- source/lamp_decoder.sv
`timescale 1ns/1ns

module lamp_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  traffic_pkg::phase_t           phase,
    input  logic                          second_half,
    input  logic                          flash_on,
    output logic [traffic_pkg::LAMPS-1:0] led_red,
    output logic [traffic_pkg::LAMPS-1:0] led_yellow,
    output logic [traffic_pkg::LAMPS-1:0] led_green,
    output logic [traffic_pkg::LAMPS-1:0] led_left,
    output logic [traffic_pkg::LAMPS-1:0] led_walk_red,
    output logic [traffic_pkg::LAMPS-1:0] led_walk_green
);

    import traffic_pkg::*;

    lamp_masks_t masks;
    logic [LAMPS-1:0] yellow_next;
    logic [LAMPS-1:0] green_next;
    logic [LAMPS-1:0] left_next;
    logic [LAMPS-1:0] walk_green_next;

    always_comb
    begin
        case (phase)
            PH_A1:   masks = MASK_A1;
            PH_A2:   masks = MASK_A2;
            PH_B:    masks = MASK_B;
            PH_C:    masks = MASK_C;
            PH_D:    masks = MASK_D;
            PH_E1:   masks = MASK_E1;
            PH_E2:   masks = MASK_E2;
            PH_F:    masks = MASK_F;
            PH_G:    masks = MASK_G;
            PH_H:    masks = MASK_H;
            default: masks = MASK_OFF;
        endcase
    end

    // second half clears green, shows yellow and blinks the walk lamps
    always_comb
    begin
        if (second_half)
        begin
            green_next = '0;
            yellow_next = masks.yellow;
            left_next = masks.left_second;
            walk_green_next = flash_on ? masks.walk_green : '0;
        end
        else
        begin
            green_next = masks.green;
            yellow_next = '0;
            left_next = masks.left_first;
            walk_green_next = masks.walk_green;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            led_red <= '0;
            led_yellow <= '0;
            led_green <= '0;
            led_left <= '0;
            led_walk_red <= '0;
            led_walk_green <= '0;
        end
        else
        begin
            // red masks do not change within a phase
            led_red <= masks.red;
            led_walk_red <= masks.walk_red;
            led_yellow <= yellow_next;
            led_green <= green_next;
            led_left <= left_next;
            led_walk_green <= walk_green_next;
        end
    end

endmodule

//--- source/traffic_top.sv
`timescale 1ns/1ns

module traffic_top #(
    parameter int TICKS_PER_STEP = 240,
    parameter int DAY_STEPS = 40,
    parameter int NIGHT_STEPS = 80,
    parameter int MANUAL_STEPS = 120
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            night,
    input  logic [traffic_pkg::BUTTONS-1:0] buttons,
    output traffic_pkg::phase_t             phase,
    output logic [traffic_pkg::LAMPS-1:0]   led_red,
    output logic [traffic_pkg::LAMPS-1:0]   led_yellow,
    output logic [traffic_pkg::LAMPS-1:0]   led_green,
    output logic [traffic_pkg::LAMPS-1:0]   led_left,
    output logic [traffic_pkg::LAMPS-1:0]   led_walk_red,
    output logic [traffic_pkg::LAMPS-1:0]   led_walk_green
);

    import traffic_pkg::*;

    logic [BUTTONS-1:0] press;
    logic manual;
    logic phase_end;
    logic second_half;
    logic flash_on;

    button_oneshot u_oneshot (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .press   (press)
    );

    phase_timer #(
        .TICKS_PER_STEP (TICKS_PER_STEP),
        .DAY_STEPS      (DAY_STEPS),
        .NIGHT_STEPS    (NIGHT_STEPS),
        .MANUAL_STEPS   (MANUAL_STEPS)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .night       (night),
        .manual      (manual),
        .phase_end   (phase_end),
        .second_half (second_half),
        .flash_on    (flash_on)
    );

    phase_sequencer u_sequencer (
        .clk       (clk),
        .rst       (rst),
        .night     (night),
        .press     (press),
        .phase_end (phase_end),
        .phase     (phase),
        .manual    (manual)
    );

    lamp_decoder u_decoder (
        .clk            (clk),
        .rst            (rst),
        .phase          (phase),
        .second_half    (second_half),
        .flash_on       (flash_on),
        .led_red        (led_red),
        .led_yellow     (led_yellow),
        .led_green      (led_green),
        .led_left       (led_left),
        .led_walk_red   (led_walk_red),
        .led_walk_green (led_walk_green)
    );

endmodule

//--- tests/traffic_model.svh
`ifndef TRAFFIC_MODEL_SVH
`define TRAFFIC_MODEL_SVH

// short timing so that every phase fits into a few dozen cycles
localparam int TICKS = 4;
localparam int DAY_LEN = 6;
localparam int NIGHT_LEN = 10;
localparam int MANUAL_LEN = 8;
localparam int unsigned SEED = 72488;

localparam int RESET_CYCLES = 10;
localparam int DAY_CYCLES = 320;
localparam int NIGHT_CYCLES = 520;
localparam int MANUAL_CYCLES = 640;
localparam int MIXED_CYCLES = 1600;
localparam int WATCHDOG_CYCLES = RESET_CYCLES + DAY_CYCLES + NIGHT_CYCLES
    + MANUAL_CYCLES + MIXED_CYCLES + 200;

localparam phase_t DAY_RING [0:5] = '{PH_A1, PH_D, PH_F, PH_E1, PH_G, PH_E2};
localparam phase_t NIGHT_RING [0:5] = '{PH_B, PH_A1, PH_C, PH_A2, PH_E1, PH_H};
localparam phase_t REQ_MAP [0:BUTTONS-1] =
    '{PH_A1, PH_B, PH_C, PH_D, PH_E1, PH_F, PH_G, PH_H};

int ref_cyc;
int ref_len;
int manual_entries;
phase_t ref_phase;
phase_t ref_req;
logic ref_manual;
logic ref_pending;
logic [BUTTONS-1:0] ref_prev;
logic [BUTTONS-1:0] ref_press;
logic [LAMPS-1:0] exp_red;
logic [LAMPS-1:0] exp_yellow;
logic [LAMPS-1:0] exp_green;
logic [LAMPS-1:0] exp_left;
logic [LAMPS-1:0] exp_walk_red;
logic [LAMPS-1:0] exp_walk_green;

// red, green, left, yellow, late left, walk red, walk green
function automatic logic [27:0] phase_masks(input phase_t p);
    case (p)
        PH_A1, PH_A2: return {4'b0101, 4'b1010, 4'b0000, 4'b1010, 4'b0000, 4'b1010, 4'b0101};
        PH_B:         return {4'b0111, 4'b1000, 4'b1000, 4'b1000, 4'b0000, 4'b1110, 4'b0001};
        PH_C:         return {4'b1101, 4'b0010, 4'b0010, 4'b0010, 4'b0000, 4'b1011, 4'b0100};
        PH_D:         return {4'b0101, 4'b0000, 4'b1010, 4'b1010, 4'b0000, 4'b1111, 4'b0000};
        PH_E1, PH_E2: return {4'b1010, 4'b0101, 4'b0000, 4'b0101, 4'b0000, 4'b0101, 4'b1010};
        PH_F:         return {4'b1011, 4'b0100, 4'b0100, 4'b0100, 4'b0100, 4'b0111, 4'b1000};
        PH_G:         return {4'b1110, 4'b0001, 4'b0001, 4'b0001, 4'b0000, 4'b1101, 4'b0010};
        PH_H:         return {4'b1010, 4'b0000, 4'b0101, 4'b0101, 4'b0000, 4'b1111, 4'b0000};
        default:      return '0;
    endcase
endfunction

// phases outside the ring fall back to its first entry
function automatic phase_t ring_next(input logic at_night, input phase_t p);
    phase_t ring [0:5];
    phase_t nxt;
    if (at_night)
        ring = NIGHT_RING;
    else
        ring = DAY_RING;
    nxt = ring[0];
    for (int k = 0; k < 6; k++)
    begin
        if (ring[k] == p)
            nxt = ring[(k + 1) % 6];
    end
    return nxt;
endfunction

function automatic phase_t lowest_request(input logic [BUTTONS-1:0] bits);
    phase_t p;
    logic found;
    p = REQ_MAP[0];
    found = 1'b0;
    for (int k = 0; k < BUTTONS; k++)
    begin
        if (bits[k] && !found)
        begin
            p = REQ_MAP[k];
            found = 1'b1;
        end
    end
    return p;
endfunction

task automatic clear_model();
    ref_cyc = 0;
    ref_len = 0;
    ref_phase = PH_B;
    ref_req = PH_A1;
    ref_manual = 1'b0;
    ref_pending = 1'b0;
    ref_prev = '0;
    ref_press = '0;
    {exp_red, exp_yellow, exp_green, exp_left, exp_walk_red, exp_walk_green} = '0;
endtask

// one clock edge, inputs as they stood before the edge
task automatic advance_model(input logic night_in, input logic [BUTTONS-1:0] buttons_in);
    logic [27:0] m;
    logic at_end;
    logic half;
    logic flash;
    if (ref_cyc == 0)
    begin
        if (ref_manual)
            ref_len = MANUAL_LEN;
        else
            ref_len = night_in ? NIGHT_LEN : DAY_LEN;
    end
    at_end = (ref_cyc == ref_len * TICKS - 1);
    half = ((ref_cyc / TICKS) >= (ref_len / 2));
    flash = ((ref_cyc % TICKS) < (TICKS / 2));
    m = phase_masks(ref_phase);
    exp_red = m[27:24];
    exp_walk_red = m[7:4];
    exp_green = half ? 4'b0000 : m[23:20];
    exp_yellow = half ? m[15:12] : 4'b0000;
    exp_left = half ? m[11:8] : m[19:16];
    exp_walk_green = (half && !flash) ? 4'b0000 : m[3:0];
    if (at_end)
    begin
        if (ref_pending)
            manual_entries++;
        ref_phase = ref_pending ? ref_req : ring_next(night_in, ref_phase);
        ref_manual = ref_pending;
        ref_cyc = 0;
    end
    else
        ref_cyc++;
    // a press in the last cycle waits for the following phase end
    if (ref_press != '0)
    begin
        ref_pending = 1'b1;
        ref_req = lowest_request(ref_press);
    end
    else if (at_end)
        ref_pending = 1'b0;
    ref_press = buttons_in & ~ref_prev;
    ref_prev = buttons_in;
endtask

`endif

//--- tests/traffic_tb.sv
`timescale 1ns/1ns

module traffic_tb;

    import traffic_pkg::*;

    `include "traffic_model.svh"

    logic clk = 1'b0;
    logic rst;
    logic night;
    logic [BUTTONS-1:0] buttons;
    phase_t phase;
    logic [LAMPS-1:0] led_red;
    logic [LAMPS-1:0] led_yellow;
    logic [LAMPS-1:0] led_green;
    logic [LAMPS-1:0] led_left;
    logic [LAMPS-1:0] led_walk_red;
    logic [LAMPS-1:0] led_walk_green;
    int unsigned rand_state;
    string test_name;

    traffic_top #(
        .TICKS_PER_STEP (TICKS),
        .DAY_STEPS      (DAY_LEN),
        .NIGHT_STEPS    (NIGHT_LEN),
        .MANUAL_STEPS   (MANUAL_LEN)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .night          (night),
        .buttons        (buttons),
        .phase          (phase),
        .led_red        (led_red),
        .led_yellow     (led_yellow),
        .led_green      (led_green),
        .led_left       (led_left),
        .led_walk_red   (led_walk_red),
        .led_walk_green (led_walk_green)
    );

    always #5 clk = ~clk;

    function automatic int unsigned next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 8;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch in %s: %s expected %0h actual %0h at %0t",
                     test_name, what, expected, actual, $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic compare_outputs();
        check_value("phase", 32'(ref_phase), 32'(phase));
        check_value("led_red", 32'(exp_red), 32'(led_red));
        check_value("led_yellow", 32'(exp_yellow), 32'(led_yellow));
        check_value("led_green", 32'(exp_green), 32'(led_green));
        check_value("led_left", 32'(exp_left), 32'(led_left));
        check_value("led_walk_red", 32'(exp_walk_red), 32'(led_walk_red));
        check_value("led_walk_green", 32'(exp_walk_green), 32'(led_walk_green));
    endtask

    // mode 0 day, 1 night, 2 buttons, 3 buttons and mode changes
    task automatic drive_inputs(input int mode);
        int unsigned r;
        r = next_random();
        if (mode < 2)
        begin
            night = (mode == 1);
            buttons = '0;
        end
        else
        begin
            if (mode == 2)
                night = 1'b0;
            // night only flips right after a phase change
            if (mode == 3 && ref_cyc == 0 && r[3:0] < 4'd6)
                night = ~night;
            if (buttons != '0)
            begin
                if (r[5:4] != 2'b00)
                    buttons = '0;
            end
            else if (r[10:6] == 5'd0)
            begin
                if (r[11])
                    buttons = BUTTONS'(1) << r[14:12];
                else
                    buttons = BUTTONS'(r >> 16);
            end
        end
    endtask

    task automatic run_section(input string name, input int cycles, input int mode);
        test_name = name;
        repeat (cycles)
        begin
            @(posedge clk);
            advance_model(night, buttons);
            #1;
            drive_inputs(mode);
            @(negedge clk);
            compare_outputs();
        end
    endtask

    initial
    begin
        rst = 1'b0;
        night = 1'b0;
        buttons = '0;
        rand_state = SEED;
        manual_entries = 0;
        clear_model();
        test_name = "reset";
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            clear_model();
            #1;
            rst = (i == RESET_CYCLES - 1);
            @(negedge clk);
            compare_outputs();
        end
        run_section("day", DAY_CYCLES, 0);
        run_section("night", NIGHT_CYCLES, 1);
        run_section("manual", MANUAL_CYCLES, 2);
        run_section("mixed", MIXED_CYCLES, 3);
        test_name = "coverage";
        check_value("manual phases entered", 1, 32'(manual_entries > 0));
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sources.f
+incdir+tests
source/traffic_pkg.sv
source/button_oneshot.sv
source/phase_timer.sv
source/phase_sequencer.sv
source/lamp_decoder.sv
source/traffic_top.sv
tests/traffic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module traffic_tb -f sources.f -Mdir obj_dir -o traffic_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/traffic_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "TEST RESULT: FAIL" "$log"; then
    echo "simulation reported failure, see $log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
